// ==== design/sd_pkg.sv ====
package sd_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] apb_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0]  cmd_index_t;
    typedef logic [6:0]  crc7_t;
    typedef logic [7:0]  clk_div_t;
    typedef logic [5:0]  bit_cnt_t;
    typedef logic [6:0]  tmo_cnt_t;

    localparam reg_addr_t ADDR_ARG        = 5'h00;
    localparam reg_addr_t ADDR_CMD        = 5'h04;
    localparam reg_addr_t ADDR_STATUS     = 5'h08;
    localparam reg_addr_t ADDR_RESP       = 5'h0C;
    localparam reg_addr_t ADDR_CLKDIV     = 5'h10;
    localparam clk_div_t  DIV_RESET       = 8'd2;
    localparam int        RESP_TIMEOUT    = 64;    // In SD clock periods
    localparam int        CMD_BITS        = 48;
    localparam int        RESP_BITS       = 48;
    localparam int        CRC_SPAN        = 40;    // Leading bits covered by CRC7
    localparam int        CMD_RESP_EN_BIT = 8;

    typedef struct packed {
        logic      valid;
        logic      write;
        reg_addr_t addr;
        word_t     wdata;
    } reg_req_t;

    typedef struct packed {
        logic  ack;
        logic  err;
        word_t rdata;
    } reg_rsp_t;

    typedef struct packed {
        logic       start;
        cmd_index_t index;
        word_t      arg;
        logic       resp_en;
        clk_div_t   div;
    } cmd_req_t;

    typedef struct packed {
        logic  busy;
        logic  done;
        logic  crc_err;
        logic  timeout;
        word_t resp_arg;
    } cmd_rsp_t;

    // STATUS register layout, bit 0 is busy
    typedef struct packed {
        logic timeout;
        logic crc_err;
        logic done;
        logic busy;
    } status_t;

    typedef enum logic [1:0] {BR_IDLE, BR_ACCESS, BR_DONE} bridge_state_e;

    typedef enum logic [2:0] {EN_IDLE, EN_SEND, EN_WAIT_RESP, EN_RECV, EN_FINISH} engine_state_e;

    // One serial step of x^7 + x^3 + 1
    function automatic crc7_t crc7_next(crc7_t crc, logic din);
        logic fb;
        fb = din ^ crc[6];
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

endpackage

// ==== design/sd_apb_bridge.sv ====
`timescale 1ns/1ps

module sd_apb_bridge (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  sd_pkg::apb_addr_t paddr_i,
    input  sd_pkg::word_t     pwdata_i,
    output sd_pkg::word_t     prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output sd_pkg::reg_req_t  req_o,
    input  sd_pkg::reg_rsp_t  rsp_i
);
    import sd_pkg::*;

    bridge_state_e state_q;
    reg_req_t      req_q;
    word_t         prdata_q;
    logic          err_q;
    logic          access;
    logic          in_range;

    assign access   = psel_i & penable_i;
    assign in_range = ~|paddr_i[$bits(apb_addr_t)-1:$bits(reg_addr_t)];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= BR_IDLE;
            req_q   <= '0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                BR_IDLE: begin
                    if (access) begin
                        if (in_range) begin
                            req_q.valid <= 1'b1;
                            req_q.write <= pwrite_i;
                            req_q.addr  <= paddr_i[$bits(reg_addr_t)-1:0];
                            req_q.wdata <= pwdata_i;
                            err_q       <= 1'b0;
                            state_q     <= BR_ACCESS;
                        end else begin
                            err_q   <= 1'b1;   // Never reaches the bank
                            state_q <= BR_DONE;
                        end
                    end
                end
                BR_ACCESS: begin
                    req_q.valid <= 1'b0;   // Single-cycle request
                    if (rsp_i.ack) begin
                        err_q   <= rsp_i.err;
                        state_q <= BR_DONE;
                    end
                end
                default: state_q <= BR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == BR_ACCESS && rsp_i.ack) begin
            prdata_q <= rsp_i.rdata;
        end else if (state_q == BR_IDLE && access && !in_range) begin
            prdata_q <= '0;
        end
    end

    assign req_o     = req_q;
    assign prdata_o  = prdata_q;
    assign pready_o  = (state_q == BR_DONE);
    assign pslverr_o = pready_o & err_q;

endmodule

// ==== design/sd_ctrl_regs.sv ====
`timescale 1ns/1ps

module sd_ctrl_regs (
    input  logic             clk,
    input  logic             rst_n,
    input  sd_pkg::reg_req_t req_i,
    output sd_pkg::reg_rsp_t rsp_o,
    output sd_pkg::cmd_req_t cmd_o,
    input  sd_pkg::cmd_rsp_t cmd_i,
    output logic             irq_o
);
    import sd_pkg::*;

    word_t      arg_q;
    word_t      resp_q;
    cmd_index_t idx_q;
    logic       resp_en_q;
    clk_div_t   div_q;
    logic       start_q;
    logic       done_q;
    logic       crc_err_q;
    logic       timeout_q;
    status_t    status;
    reg_rsp_t   rsp_q;
    word_t      rdata;
    logic       hit;
    logic       wr;

    assign wr     = req_i.valid & req_i.write;
    assign status = '{timeout: timeout_q, crc_err: crc_err_q, done: done_q, busy: cmd_i.busy};

    // Read mux, unmapped offsets answer with an error
    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (req_i.addr)
            ADDR_ARG:    rdata = arg_q;
            ADDR_CMD:    rdata = word_t'({resp_en_q, 2'b00, idx_q});
            ADDR_STATUS: rdata = word_t'(status);
            ADDR_RESP:   rdata = resp_q;
            ADDR_CLKDIV: rdata = word_t'(div_q);
            default:     hit   = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_q     <= '0;
            idx_q     <= '0;
            resp_en_q <= 1'b0;
            div_q     <= DIV_RESET;
            start_q   <= 1'b0;
            done_q    <= 1'b0;
            crc_err_q <= 1'b0;
            timeout_q <= 1'b0;
        end else begin
            rsp_q.ack   <= req_i.valid;
            rsp_q.err   <= req_i.valid & ~hit;
            rsp_q.rdata <= rdata;
            start_q     <= wr && (req_i.addr == ADDR_CMD);
            if (wr && req_i.addr == ADDR_CMD) begin
                idx_q     <= req_i.wdata[$bits(cmd_index_t)-1:0];
                resp_en_q <= req_i.wdata[CMD_RESP_EN_BIT];
            end
            if (wr && req_i.addr == ADDR_CLKDIV) begin
                div_q <= req_i.wdata[$bits(clk_div_t)-1:0];
            end
            if (wr && req_i.addr == ADDR_STATUS) begin
                done_q    <= 1'b0;   // Any value clears the flags
                crc_err_q <= 1'b0;
                timeout_q <= 1'b0;
            end
            if (cmd_i.done) begin
                done_q    <= 1'b1;
                crc_err_q <= cmd_i.crc_err;
                timeout_q <= cmd_i.timeout;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && req_i.addr == ADDR_ARG) begin
            arg_q <= req_i.wdata;
        end
        if (cmd_i.done) begin
            resp_q <= cmd_i.resp_arg;
        end
    end

    assign rsp_o = rsp_q;
    assign cmd_o = '{start: start_q, index: idx_q, arg: arg_q, resp_en: resp_en_q, div: div_q};
    assign irq_o = done_q;

endmodule

// ==== design/sd_cmd_engine.sv ====
`timescale 1ns/1ps

module sd_cmd_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  sd_pkg::cmd_req_t req_i,
    output sd_pkg::cmd_rsp_t rsp_o,
    output logic             sd_clk_o,
    output logic             sd_cmd_o,
    output logic             sd_cmd_oe_o,
    input  logic             sd_cmd_i
);
    import sd_pkg::*;

    engine_state_e          state_q;
    clk_div_t               div_cnt_q;
    logic                   sd_clk_q;
    logic                   tick;
    logic                   rise_en;
    logic                   fall_en;
    logic [CMD_BITS-1:0]    frame_q;
    logic [RESP_BITS-1:0]   rx_q;
    crc7_t                  crc_q;
    bit_cnt_t               bit_cnt_q;
    tmo_cnt_t               tmo_cnt_q;
    logic                   resp_en_q;
    logic                   timeout_q;
    logic                   sd_cmd_q;
    logic                   sd_cmd_oe_q;

    // Free-running divider, half period is div + 1 clk cycles
    assign tick    = (div_cnt_q >= req_i.div);
    assign rise_en = tick & ~sd_clk_q;
    assign fall_en = tick & sd_clk_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt_q <= '0;
            sd_clk_q  <= 1'b0;
        end else if (tick) begin
            div_cnt_q <= '0;
            sd_clk_q  <= ~sd_clk_q;
        end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= EN_IDLE;
            frame_q     <= '0;
            rx_q        <= '0;
            crc_q       <= '0;
            bit_cnt_q   <= '0;
            tmo_cnt_q   <= '0;
            resp_en_q   <= 1'b0;
            timeout_q   <= 1'b0;
            sd_cmd_q    <= 1'b1;
            sd_cmd_oe_q <= 1'b0;
        end else begin
            case (state_q)
                EN_IDLE: begin
                    if (req_i.start) begin
                        frame_q   <= {2'b01, req_i.index, req_i.arg, 7'd0, 1'b1};
                        crc_q     <= '0;
                        bit_cnt_q <= '0;
                        resp_en_q <= req_i.resp_en;
                        timeout_q <= 1'b0;
                        state_q   <= EN_SEND;
                    end
                end
                EN_SEND: if (fall_en) begin
                    if (bit_cnt_q == bit_cnt_t'(CMD_BITS)) begin
                        sd_cmd_oe_q <= 1'b0;   // Release line after end bit
                        sd_cmd_q    <= 1'b1;
                        tmo_cnt_q   <= '0;
                        state_q     <= resp_en_q ? EN_WAIT_RESP : EN_FINISH;
                    end else begin
                        sd_cmd_oe_q <= 1'b1;
                        sd_cmd_q    <= frame_q[CMD_BITS-1];
                        bit_cnt_q   <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q < bit_cnt_t'(CRC_SPAN)) begin
                            crc_q <= crc7_next(crc_q, frame_q[CMD_BITS-1]);
                        end
                        // CRC slots in behind the argument
                        if (bit_cnt_q == bit_cnt_t'(CRC_SPAN - 1)) begin
                            frame_q <= {crc7_next(crc_q, frame_q[CMD_BITS-1]), 1'b1, 40'd0};
                        end else begin
                            frame_q <= {frame_q[CMD_BITS-2:0], 1'b1};
                        end
                    end
                end
                EN_WAIT_RESP: if (rise_en) begin
                    if (!sd_cmd_i) begin
                        rx_q      <= {rx_q[RESP_BITS-2:0], 1'b0};
                        crc_q     <= crc7_next('0, 1'b0);
                        bit_cnt_q <= bit_cnt_t'(1);
                        state_q   <= EN_RECV;
                    end else if (tmo_cnt_q == tmo_cnt_t'(RESP_TIMEOUT - 1)) begin
                        timeout_q <= 1'b1;
                        state_q   <= EN_FINISH;
                    end else begin
                        tmo_cnt_q <= tmo_cnt_q + 1'b1;
                    end
                end
                EN_RECV: if (rise_en) begin
                    rx_q      <= {rx_q[RESP_BITS-2:0], sd_cmd_i};
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (bit_cnt_q < bit_cnt_t'(CRC_SPAN)) begin
                        crc_q <= crc7_next(crc_q, sd_cmd_i);
                    end
                    if (bit_cnt_q == bit_cnt_t'(RESP_BITS - 1)) begin
                        state_q <= EN_FINISH;
                    end
                end
                default: state_q <= EN_IDLE;   // One cycle for done
            endcase
        end
    end

    assign rsp_o.busy     = (state_q != EN_IDLE);
    assign rsp_o.done     = (state_q == EN_FINISH);
    assign rsp_o.timeout  = timeout_q;
    assign rsp_o.crc_err  = resp_en_q & ~timeout_q & (rx_q[7:1] != crc_q);
    assign rsp_o.resp_arg = rx_q[39:8];

    assign sd_clk_o    = sd_clk_q;
    assign sd_cmd_o    = sd_cmd_q;
    assign sd_cmd_oe_o = sd_cmd_oe_q;

endmodule

// ==== design/sd_host_top.sv ====
`timescale 1ns/1ps

module sd_host_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  sd_pkg::apb_addr_t paddr_i,
    input  sd_pkg::word_t     pwdata_i,
    output sd_pkg::word_t     prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    output logic              irq_o,
    output logic              sd_clk_o,
    output logic              sd_cmd_o,
    output logic              sd_cmd_oe_o,
    input  logic              sd_cmd_i
);
    import sd_pkg::*;

    reg_req_t reg_req;
    reg_rsp_t reg_rsp;
    cmd_req_t cmd_req;
    cmd_rsp_t cmd_rsp;

    sd_apb_bridge sd_apb_bridge_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .req_o     (reg_req),
        .rsp_i     (reg_rsp)
    );

    sd_ctrl_regs sd_ctrl_regs_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (reg_req),
        .rsp_o (reg_rsp),
        .cmd_o (cmd_req),
        .cmd_i (cmd_rsp),
        .irq_o (irq_o)
    );

    // Command line leaves as separate out, enable and in
    sd_cmd_engine sd_cmd_engine_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (cmd_req),
        .rsp_o       (cmd_rsp),
        .sd_clk_o    (sd_clk_o),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o),
        .sd_cmd_i    (sd_cmd_i)
    );

endmodule

// ==== testbench/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model (
    input  logic sd_clk_i,
    input  logic host_oe_i,
    input  logic cmd_line_i,
    output logic cmd_o,
    output logic cmd_oe_o
);

    logic [47:0] rx_frame;

    // Remainder of msg * x^7 divided by x^7 + x^3 + 1
    function automatic logic [6:0] crc7_of(input logic [39:0] msg);
        logic [46:0] rem;
        rem = {msg, 7'd0};
        for (int i = 46; i >= 7; i--) begin
            if (rem[i]) begin
                rem[i -: 8] = rem[i -: 8] ^ 8'b1000_1001;
            end
        end
        return rem[6:0];
    endfunction

    task automatic send_response(input logic [5:0] index, input logic [31:0] arg);
        logic [6:0]  crc;
        logic [47:0] frame;
        crc = crc7_of({2'b00, index, arg});
        if (index == 6'd42) begin
            crc = ~crc;   // Corrupted on purpose
        end
        frame = {2'b00, index, arg, crc, 1'b1};
        for (int i = 47; i >= 0; i--) begin
            @(negedge sd_clk_i);
            cmd_oe_o <= 1'b1;
            cmd_o    <= frame[i];
        end
        @(negedge sd_clk_i);
        cmd_oe_o <= 1'b0;
        cmd_o    <= 1'b1;
    endtask

    initial begin
        cmd_o    = 1'b1;
        cmd_oe_o = 1'b0;
        forever begin
            @(posedge sd_clk_i);
            if (host_oe_i && !cmd_line_i) begin
                rx_frame = '0;   // Start bit already seen
                for (int i = 46; i >= 0; i--) begin
                    @(posedge sd_clk_i);
                    rx_frame[i] = cmd_line_i;
                end
                // A real card stays silent on a broken frame
                if (rx_frame[46] && rx_frame[0] && rx_frame[7:1] == crc7_of(rx_frame[47:8])
                    && rx_frame[45:40] != 6'd0) begin
                    repeat (2) @(posedge sd_clk_i);
                    send_response(rx_frame[45:40], ~rx_frame[39:8]);
                end
            end
        end
    end

endmodule

// ==== testbench/sd_host_assert.sv ====
`timescale 1ns/1ps

module sd_host_assert (
    input logic             clk,
    input logic             rst_n,
    input logic             psel_i,
    input logic             pready_i,
    input logic             irq_i,
    input logic             sd_cmd_oe_i,
    input sd_pkg::reg_req_t reg_req_i,
    input sd_pkg::cmd_rsp_t cmd_rsp_i
);
    import sd_pkg::*;

    pready_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        pready_i |-> psel_i)
        else $error("pready_o high while psel_i is low");

    // Line stays released whenever the engine is idle
    idle_line_released: assert property (@(posedge clk) disable iff (!rst_n)
        !cmd_rsp_i.busy |-> !sd_cmd_oe_i)
        else $error("sd_cmd_oe_o high while the engine is idle");

    irq_cleared_by_status_write: assert property (@(posedge clk) disable iff (!rst_n)
        (reg_req_i.valid && reg_req_i.write && reg_req_i.addr == ADDR_STATUS
         && !cmd_rsp_i.done) |=> !irq_i)
        else $error("irq_o still high after a STATUS write");

endmodule

bind sd_host_top sd_host_assert sd_host_assert_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel_i      (psel_i),
    .pready_i    (pready_o),
    .irq_i       (irq_o),
    .sd_cmd_oe_i (sd_cmd_oe_o),
    .reg_req_i   (reg_req),
    .cmd_rsp_i   (cmd_rsp)
);

// ==== testbench/tb_sd_host.sv ====
`timescale 1ns/1ps

module tb_sd_host;
    import sd_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_TESTS   = 7;
    localparam int TEST_CYCLES = 4000;   // Slowest divider with a full response timeout
    localparam int WATCHDOG_NS = (NUM_TESTS + 1) * TEST_CYCLES * CLK_PERIOD;
    localparam int MAX_POLLS   = 600;
    localparam int READY_CYCLE = 4;      // pready 3 cycles after the first access cycle
    localparam int ERR_CYCLE   = 2;

    typedef struct {
        string      name;
        cmd_index_t index;
        word_t      arg;
        logic       resp_en;
        clk_div_t   div;
        logic [3:0] status;   // {timeout, crc_err, done, busy}
        logic       resp_chk;
        word_t      resp;
    } test_entry_t;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    word_t       pwdata;
    word_t       prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;
    logic        sd_clk;
    logic        sd_cmd;
    logic        sd_cmd_oe;
    logic        sd_cmd_line;
    logic        card_cmd;
    logic        card_oe;
    test_entry_t tests[$];
    int          errors;

    // Pull-up when nobody drives the line
    assign sd_cmd_line = sd_cmd_oe ? sd_cmd : (card_oe ? card_cmd : 1'b1);

    sd_host_top sd_host_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .irq_o       (irq),
        .sd_clk_o    (sd_clk),
        .sd_cmd_o    (sd_cmd),
        .sd_cmd_oe_o (sd_cmd_oe),
        .sd_cmd_i    (sd_cmd_line)
    );

    sd_card_model sd_card_model_i (
        .sd_clk_i   (sd_clk),
        .host_oe_i  (sd_cmd_oe),
        .cmd_line_i (sd_cmd_line),
        .cmd_o      (card_cmd),
        .cmd_oe_o   (card_oe)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic add_test(input string name, input cmd_index_t index, input logic resp_en,
                            input clk_div_t div, input logic [3:0] status, input logic resp_chk);
        test_entry_t t;
        t.name     = name;
        t.index    = index;
        t.arg      = $urandom();
        t.resp_en  = resp_en;
        t.div      = div;
        t.status   = status;
        t.resp_chk = resp_chk;
        t.resp     = ~t.arg;   // Card echoes the inverted argument
        tests.push_back(t);
    endtask

    task automatic apb_transfer(input logic write, input apb_addr_t addr, input word_t wdata,
                                output word_t rdata, output logic err, output int waits);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
        end while (!pready && waits < 16);
        rdata = prdata;
        err   = pslverr;
        if (!pready) begin
            errors++;
            $display("APB access at %h never got pready", addr);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        word_t rd;
        logic  err;
        int    waits;
        apb_transfer(1'b1, apb_addr_t'(addr), data, rd, err, waits);
        if (err !== 1'b0 || waits != READY_CYCLE) begin
            errors++;
            $display("Write to offset %h: pslverr %b, pready in access cycle %0d", addr, err, waits);
        end
    endtask

    task automatic read_reg(input reg_addr_t addr, output word_t data);
        logic err;
        int   waits;
        apb_transfer(1'b0, apb_addr_t'(addr), '0, data, err, waits);
        if (err !== 1'b0 || waits != READY_CYCLE) begin
            errors++;
            $display("Read of offset %h: pslverr %b, pready in access cycle %0d", addr, err, waits);
        end
    endtask

    // Rise to rise of sd_clk_o, counted in clk cycles
    task automatic check_sd_clk_period(input string name, input clk_div_t div);
        int   first;
        int   second;
        int   n;
        int   limit;
        logic prev;
        first  = -1;
        second = -1;
        limit  = 4 * (int'(div) + 1) + 4;
        @(negedge clk);
        prev = sd_clk;
        for (n = 1; n <= limit && second < 0; n++) begin
            @(negedge clk);
            if (sd_clk && !prev) begin
                if (first < 0) begin
                    first = n;
                end else begin
                    second = n;
                end
            end
            prev = sd_clk;
        end
        if (second < 0) begin
            errors++;
            $display("%s: sd_clk_o did not complete a period in %0d clk cycles", name, limit);
        end else if (second - first != 2 * (int'(div) + 1)) begin
            report_mismatch({name, " sd_clk period"}, word_t'(2 * (int'(div) + 1)),
                            word_t'(second - first));
        end
    endtask

    task automatic wait_done(input string name, output word_t status);
        int polls;
        polls = 0;
        do begin
            read_reg(ADDR_STATUS, status);
            polls++;
        end while (!status[1] && polls < MAX_POLLS);
        if (!status[1]) begin
            errors++;
            $display("%s: done bit not set after %0d STATUS reads", name, polls);
        end
    endtask

    task automatic run_entry(input test_entry_t t);
        word_t rd;
        write_reg(ADDR_CLKDIV, word_t'(t.div));
        check_sd_clk_period(t.name, t.div);
        write_reg(ADDR_ARG, t.arg);
        write_reg(ADDR_CMD, {23'd0, t.resp_en, 2'b00, t.index});
        read_reg(ADDR_STATUS, rd);
        if (rd[0] !== 1'b1) report_mismatch({t.name, " busy"}, 32'h1, word_t'(rd[0]));
        wait_done(t.name, rd);
        if (rd !== {28'd0, t.status}) report_mismatch({t.name, " status"}, {28'd0, t.status}, rd);
        if (t.resp_chk) begin
            read_reg(ADDR_RESP, rd);
            if (rd !== t.resp) report_mismatch({t.name, " resp"}, t.resp, rd);
        end
        @(negedge clk);
        if (irq !== 1'b1) report_mismatch({t.name, " irq set"}, 32'h1, word_t'(irq));
        write_reg(ADDR_STATUS, 32'hffff_ffff);
        @(negedge clk);
        if (irq !== 1'b0) report_mismatch({t.name, " irq clear"}, 32'h0, word_t'(irq));
        read_reg(ADDR_STATUS, rd);
        if (rd !== 32'h0) report_mismatch({t.name, " status clear"}, 32'h0, rd);
    endtask

    initial begin
        word_t rd;
        word_t arg;
        logic  err;
        int    waits;
        errors  = 0;
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'hdb1e));

        // Name, index, resp_en, div, expected STATUS, RESP checked
        add_test("cmd17_div0", 6'd17, 1'b1, 8'd0, 4'b0010, 1'b1);
        add_test("cmd55_div0", 6'd55, 1'b1, 8'd0, 4'b0010, 1'b1);
        add_test("cmd17_div3", 6'd17, 1'b1, 8'd3, 4'b0010, 1'b1);
        add_test("cmd55_div3", 6'd55, 1'b1, 8'd3, 4'b0010, 1'b1);
        add_test("cmd0_timeout", 6'd0, 1'b1, 8'd1, 4'b1010, 1'b0);
        add_test("cmd42_crc_err", 6'd42, 1'b1, 8'd2, 4'b0110, 1'b1);
        add_test("cmd7_no_resp", 6'd7, 1'b0, 8'd1, 4'b0010, 1'b0);   // Card still answers, so last

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (pready || pslverr || irq || sd_cmd_oe || !sd_cmd) begin
            errors++;
            $display("Outputs not at their reset values after reset");
        end

        arg = $urandom();
        write_reg(ADDR_ARG, arg);
        read_reg(ADDR_ARG, rd);
        if (rd !== arg) report_mismatch("arg_readback", arg, rd);
        write_reg(ADDR_CLKDIV, 32'h0000_005a);
        read_reg(ADDR_CLKDIV, rd);
        if (rd !== 32'h0000_005a) report_mismatch("clkdiv_readback", 32'h0000_005a, rd);
        apb_transfer(1'b0, 16'h0040, '0, rd, err, waits);
        if (err !== 1'b1 || waits != ERR_CYCLE) begin
            errors++;
            $display("Access at 0040: pslverr %b, pready in access cycle %0d", err, waits);
        end

        foreach (tests[i]) begin
            run_entry(tests[i]);
        end

        $display("Errors: %0d in %0d command tests", errors, tests.size());
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== all.f ====
design/sd_pkg.sv
design/sd_apb_bridge.sv
design/sd_ctrl_regs.sv
design/sd_cmd_engine.sv
design/sd_host_top.sv
testbench/sd_card_model.sv
testbench/sd_host_assert.sv
testbench/tb_sd_host.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_sd_host -f all.f -o tb_sd_host; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sd_host 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" <<< "$output"; then
    exit 0
fi
exit 1
